// File: run_sim.sh
#!/bin/sh
# Build and run the DMMU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module dmmu_tb -Mdir obj_dir -o dmmu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build error"
  exit 1
fi

./obj_dir/dmmu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Verification passed$" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: source/dmmu_pkg.sv
// Data MMU shared definitions
// Field positions, SPR map, bus structs and the TLB word views
`default_nettype none

package dmmu_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  // Operand and address width
  localparam int dmmu_addr_w = 32;
  // Direct mapped, one way
  localparam int dtlb_set_w = 6;
  localparam int dtlb_sets = 1 << dtlb_set_w;
  // 8 KB pages
  localparam int page_bits = 13;

  //////////////////////////////
  // SPR map
  //////////////////////////////

  localparam int spr_addr_w = 16;
  // Group number sits in the top bits
  localparam int spr_group_w = 5;
  localparam logic [spr_group_w-1:0] spr_group_dmmu = 5'd1;
  // Set index in the low bits of each range
  localparam logic [spr_addr_w-1:0] spr_dtlb_match_base = 16'h0A00;
  localparam logic [spr_addr_w-1:0] spr_dtlb_trans_base = 16'h0A80;

  //////////////////////////////
  // Bus structs
  //////////////////////////////

  // Lookup request
  typedef struct packed {
    logic [dmmu_addr_w-1:0] vaddr;
    logic                   op_load;
    logic                   op_store;
    logic                   supervisor;
  } dmmu_req_t;

  // Lookup response
  typedef struct packed {
    logic [dmmu_addr_w-1:0] paddr;
    logic                   tlb_miss;
    logic                   pagefault;
    logic                   cache_inhibit;
  } dmmu_rsp_t;

  // One SPR cycle, strobe travels beside it
  typedef struct packed {
    logic [spr_addr_w-1:0]  addr;
    logic                   we;
    logic [dmmu_addr_w-1:0] dat;
  } spr_req_t;

  //////////////////////////////
  // TLB words
  //////////////////////////////

  // Match word, page number and valid
  typedef struct packed {
    logic [dmmu_addr_w-page_bits-1:0] vpn;
    logic [11:0]                      reserved;
    logic                             valid;
  } dtlb_match_f_t;

  typedef union packed {
    logic [dmmu_addr_w-1:0] raw;
    dtlb_match_f_t          fields;
  } dtlb_match_u;

  // Translate word, page number, rights and cache attributes
  typedef struct packed {
    logic [dmmu_addr_w-page_bits-1:0] ppn;
    logic [2:0]                       reserved;
    logic swe;
    logic sre;
    logic uwe;
    logic ure;
    logic dirty;
    logic accessed;
    logic wom;
    logic wbc;
    logic ci;
    logic cc;
  } dtlb_trans_f_t;

  typedef union packed {
    logic [dmmu_addr_w-1:0] raw;
    dtlb_trans_f_t          fields;
  } dtlb_trans_u;

endpackage

`default_nettype wire

// File: source/dmmu_spr_regs.sv
// DMMU SPR interface
// Decodes group 1 accesses, writes the TLB arrays through port A
// and returns the stored words with a one cycle acknowledge
`timescale 1ns/1ns
`default_nettype none

module dmmu_spr_regs (
  input  wire                                  clk,
  input  wire                                  rst,
  input  logic                                 spr_stb_i,
  input  dmmu_pkg::spr_req_t                   spr_req_i,
  output logic                                 spr_ack_o,
  output logic [dmmu_pkg::dmmu_addr_w-1:0]     spr_dat_o,
  // TLB port A
  output logic [dmmu_pkg::dtlb_set_w-1:0]      tlb_set_o,
  output logic                                 match_we_o,
  output logic                                 trans_we_o,
  output logic [dmmu_pkg::dmmu_addr_w-1:0]     wdat_o,
  input  dmmu_pkg::dtlb_match_u                match_rdat_i,
  input  dmmu_pkg::dtlb_trans_u                trans_rdat_i
);

  import dmmu_pkg::*;

  logic [spr_addr_w-1:0] match_off;
  logic [spr_addr_w-1:0] trans_off;
  logic                  grp_hit;
  logic                  match_hit;
  logic                  trans_hit;
  logic                  spr_new;
  logic                  ack_q;
  logic                  sel_match_q;
  logic                  sel_trans_q;

  //////////////////////////////
  // Address decode
  //////////////////////////////

  // Group field in the top address bits
  assign grp_hit = spr_req_i.addr[spr_addr_w-1 -: spr_group_w] == spr_group_dmmu;

  // Offsets into each register range
  assign match_off = spr_req_i.addr - spr_dtlb_match_base;
  assign trans_off = spr_req_i.addr - spr_dtlb_trans_base;
  assign match_hit = match_off < spr_addr_w'(dtlb_sets);
  assign trans_hit = trans_off < spr_addr_w'(dtlb_sets);

  // First strobe cycle only, master drops strobe after ack
  assign spr_new = spr_stb_i & grp_hit & ~ack_q;

  // Port A drive, write lands on the edge that raises ack
  assign tlb_set_o  = spr_req_i.addr[dtlb_set_w-1:0];
  assign wdat_o     = spr_req_i.dat;
  assign match_we_o = spr_new & spr_req_i.we & match_hit;
  assign trans_we_o = spr_new & spr_req_i.we & trans_hit;

  //////////////////////////////
  // Acknowledge and read return
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q       <= 1'b0;
      sel_match_q <= 1'b0;
      sel_trans_q <= 1'b0;
    end else begin
      // Single cycle pulse
      ack_q <= spr_new;
      if (spr_new) begin
        sel_match_q <= match_hit;
        sel_trans_q <= trans_hit;
      end
    end
  end

  assign spr_ack_o = ack_q;

  // Unused group 1 addresses read as zero
  always_comb begin
    spr_dat_o = '0;
    if (sel_match_q) begin
      spr_dat_o = match_rdat_i.raw;
    end else if (sel_trans_q) begin
      spr_dat_o = trans_rdat_i.raw;
    end
  end

endmodule

`default_nettype wire

// File: source/dmmu_top.sv
// Data MMU top level
// SPR block and lookup pipeline sharing the match and translate arrays
`timescale 1ns/1ns
`default_nettype none

module dmmu_top (
  input  wire                               clk,
  input  wire                               rst,
  // SPR bus
  input  logic                              spr_stb_i,
  input  dmmu_pkg::spr_req_t                spr_req_i,
  output logic                              spr_ack_o,
  output logic [dmmu_pkg::dmmu_addr_w-1:0]  spr_dat_o,
  // Lookup
  input  logic                              req_valid_i,
  output logic                              req_ready_o,
  input  dmmu_pkg::dmmu_req_t               req_i,
  output logic                              rsp_valid_o,
  input  logic                              rsp_ready_i,
  output dmmu_pkg::dmmu_rsp_t               rsp_o
);

  import dmmu_pkg::*;

  // Port A, SPR side
  logic [dtlb_set_w-1:0]  spr_set;
  logic                   match_we;
  logic                   trans_we;
  logic [dmmu_addr_w-1:0] spr_wdat;
  dtlb_match_u            match_a_dout;
  dtlb_trans_u            trans_a_dout;
  // Port B, lookup side
  logic [dtlb_set_w-1:0]  lkp_set;
  logic                   lkp_re;
  dtlb_match_u            match_b_dout;
  dtlb_trans_u            trans_b_dout;

  dmmu_spr_regs i_dmmu_spr_regs (
    .clk          (clk),
    .rst          (rst),
    .spr_stb_i    (spr_stb_i),
    .spr_req_i    (spr_req_i),
    .spr_ack_o    (spr_ack_o),
    .spr_dat_o    (spr_dat_o),
    .tlb_set_o    (spr_set),
    .match_we_o   (match_we),
    .trans_we_o   (trans_we),
    .wdat_o       (spr_wdat),
    .match_rdat_i (match_a_dout),
    .trans_rdat_i (trans_a_dout)
  );

  // Match words
  dtlb_ram #(
    .data_w ($bits(dtlb_match_u)),
    .addr_w (dtlb_set_w)
  ) i_dtlb_match_ram (
    .clk      (clk),
    .a_addr_i (spr_set),
    .a_we_i   (match_we),
    .a_din_i  (spr_wdat),
    .a_dout_o (match_a_dout),
    .b_addr_i (lkp_set),
    .b_re_i   (lkp_re),
    .b_dout_o (match_b_dout)
  );

  // Translate words
  dtlb_ram #(
    .data_w ($bits(dtlb_trans_u)),
    .addr_w (dtlb_set_w)
  ) i_dtlb_trans_ram (
    .clk      (clk),
    .a_addr_i (spr_set),
    .a_we_i   (trans_we),
    .a_din_i  (spr_wdat),
    .a_dout_o (trans_a_dout),
    .b_addr_i (lkp_set),
    .b_re_i   (lkp_re),
    .b_dout_o (trans_b_dout)
  );

  dtlb_lookup i_dtlb_lookup (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o),
    .ram_set_o   (lkp_set),
    .ram_re_o    (lkp_re),
    .match_i     (match_b_dout),
    .trans_i     (trans_b_dout)
  );

endmodule

`default_nettype wire

// File: source/dtlb_lookup.sv
// DTLB lookup pipeline
// Stage 1 addresses the TLB arrays, stage 2 checks hit and rights
// and registers the physical address, with valid/ready on both sides
`timescale 1ns/1ns
`default_nettype none

module dtlb_lookup (
  input  wire                               clk,
  input  wire                               rst,
  // Request side
  input  logic                              req_valid_i,
  output logic                              req_ready_o,
  input  dmmu_pkg::dmmu_req_t               req_i,
  // Response side
  output logic                              rsp_valid_o,
  input  logic                              rsp_ready_i,
  output dmmu_pkg::dmmu_rsp_t               rsp_o,
  // TLB port B
  output logic [dmmu_pkg::dtlb_set_w-1:0]   ram_set_o,
  output logic                              ram_re_o,
  input  dmmu_pkg::dtlb_match_u             match_i,
  input  dmmu_pkg::dtlb_trans_u             trans_i
);

  import dmmu_pkg::*;

  logic      advance;
  logic      s1_valid_q;
  dmmu_req_t s1_req_q;
  logic      rsp_valid_q;
  dmmu_rsp_t rsp_q;
  logic      hit;
  logic      can_read;
  logic      can_write;
  logic      fault;
  dmmu_rsp_t rsp_d;

  // Whole pipe moves unless the response is stuck
  assign advance     = ~rsp_valid_q | rsp_ready_i;
  assign req_ready_o = advance;

  //////////////////////////////
  // Stage 1
  //////////////////////////////

  // Set index straight from the incoming address
  assign ram_set_o = req_i.vaddr[page_bits +: dtlb_set_w];
  // RAM output frozen together with stage 1
  assign ram_re_o  = advance;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid_q <= 1'b0;
    end else if (advance) begin
      s1_valid_q <= req_valid_i;
    end
  end

  // Captured request payload
  always_ff @(posedge clk) begin
    if (advance) begin
      s1_req_q <= req_i;
    end
  end

  //////////////////////////////
  // Stage 2
  //////////////////////////////

  // Page number compare against the match word
  assign hit = match_i.fields.valid &&
               (match_i.fields.vpn == s1_req_q.vaddr[dmmu_addr_w-1:page_bits]);

  // Rights by privilege level
  assign can_read  = s1_req_q.supervisor ? trans_i.fields.sre : trans_i.fields.ure;
  assign can_write = s1_req_q.supervisor ? trans_i.fields.swe : trans_i.fields.uwe;

  // No fault on a miss
  assign fault = hit & ((s1_req_q.op_store & ~can_write) |
                        (s1_req_q.op_load & ~can_read));

  always_comb begin
    rsp_d               = '0;
    rsp_d.tlb_miss      = ~hit;
    rsp_d.pagefault     = fault;
    rsp_d.cache_inhibit = hit & trans_i.fields.ci;
    // ppn joined with the page offset on a hit only
    if (hit) begin
      rsp_d.paddr = {trans_i.fields.ppn, s1_req_q.vaddr[page_bits-1:0]};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid_q <= 1'b0;
    end else if (advance) begin
      rsp_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

// File: source/dtlb_ram.sv
// TLB storage array
// True dual port RAM, port A read/write, port B read only with enable
`timescale 1ns/1ns
`default_nettype none

module dtlb_ram #(
  parameter int data_w = 32,
  parameter int addr_w = 6
) (
  input  wire               clk,
  // Port A, SPR side
  input  logic [addr_w-1:0] a_addr_i,
  input  logic              a_we_i,
  input  logic [data_w-1:0] a_din_i,
  output logic [data_w-1:0] a_dout_o,
  // Port B, lookup side
  input  logic [addr_w-1:0] b_addr_i,
  input  logic              b_re_i,
  output logic [data_w-1:0] b_dout_o
);

  localparam int depth = 1 << addr_w;

  logic [data_w-1:0] mem [depth];

  // Port A write, read gives the old word
  always_ff @(posedge clk) begin
    if (a_we_i) begin
      mem[a_addr_i] <= a_din_i;
    end
    a_dout_o <= mem[a_addr_i];
  end

  // Port B holds its output while disabled
  always_ff @(posedge clk) begin
    if (b_re_i) begin
      b_dout_o <= mem[b_addr_i];
    end
  end

endmodule

`default_nettype wire

// File: verification/dmmu_tb.sv
// Data MMU testbench
// Replays SPR accesses and lookups from the test data file,
// with random response back-pressure on the lookup side
`timescale 1ns/1ns
`default_nettype none

module dmmu_tb;

  import dmmu_pkg::*;

  logic        clk = 1'b0;
  logic        rst;
  logic        spr_stb_i;
  spr_req_t    spr_req_i;
  logic        spr_ack_o;
  logic [dmmu_addr_w-1:0] spr_dat_o;
  logic        req_valid_i;
  logic        req_ready_o;
  dmmu_req_t   req_i;
  logic        rsp_valid_o;
  logic        rsp_ready_i;
  dmmu_rsp_t   rsp_o;

  // Parsed data lines with their line numbers
  string       lines[$];
  int          line_nos[$];
  // Pending lookups and what should come back
  dmmu_req_t   req_q[$];
  dmmu_rsp_t   exp_q[$];
  string       name_q[$];
  int          cycles = 0;
  int          cycle_limit = 0;
  integer      seed = 32'h7756aef0;

  dmmu_top i_dmmu_top (
    .clk         (clk),
    .rst         (rst),
    .spr_stb_i   (spr_stb_i),
    .spr_req_i   (spr_req_i),
    .spr_ack_o   (spr_ack_o),
    .spr_dat_o   (spr_dat_o),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o)
  );

  // 8 ns period
  always #4 clk = ~clk;

  //////////////////////////////
  // Error handling
  //////////////////////////////

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  // Bound on the whole run
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      stop_with_error($sformatf("Timeout, run took more than %0d cycles", cycle_limit));
    end
  end

  task automatic check_rsp(input string name, input dmmu_rsp_t exp, input dmmu_rsp_t act);
    if (act !== exp) begin
      stop_with_error($sformatf(
        "FAILED %s expected paddr=%h miss=%b fault=%b ci=%b actual paddr=%h miss=%b fault=%b ci=%b",
        name, exp.paddr, exp.tlb_miss, exp.pagefault, exp.cache_inhibit,
        act.paddr, act.tlb_miss, act.pagefault, act.cache_inhibit));
    end
  endtask

  task automatic check_spr_dat(input string name, input logic [dmmu_addr_w-1:0] exp,
                               input logic [dmmu_addr_w-1:0] act);
    if (act !== exp) begin
      stop_with_error($sformatf("FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  //////////////////////////////
  // SPR bus
  //////////////////////////////

  // One access with its read data checked in the ack cycle
  task automatic spr_access(input string name, input logic [spr_addr_w-1:0] addr,
                            input logic we, input logic [dmmu_addr_w-1:0] dat);
    int waited;
    waited = 0;
    @(negedge clk);
    spr_stb_i      = 1'b1;
    spr_req_i.addr = addr;
    spr_req_i.we   = we;
    spr_req_i.dat  = we ? dat : '0;
    // Cycle counter bounds this wait
    do begin
      @(posedge clk);
      #1;
      waited++;
    end while (!spr_ack_o);
    if (waited != 1) begin
      stop_with_error($sformatf("%s: acknowledge came %0d cycles after the strobe",
                                name, waited));
    end else begin
      if (!we) begin
        check_spr_dat(name, dat, spr_dat_o);
      end
      @(negedge clk);
      spr_stb_i = 1'b0;
      @(posedge clk);
      #1;
      // Ack is a single cycle pulse
      if (spr_ack_o) begin
        stop_with_error($sformatf("%s: acknowledge stayed high a second cycle", name));
      end
    end
  endtask

  //////////////////////////////
  // Lookups
  //////////////////////////////

  // Back to back issue under random rsp_ready_i
  task automatic run_lookups();
    int          issued;
    int          done;
    logic [31:0] rnd;
    dmmu_rsp_t   exp;
    issued = 0;
    done   = 0;
    while (done < req_q.size()) begin
      @(negedge clk);
      if (issued < req_q.size()) begin
        req_valid_i = 1'b1;
        req_i       = req_q[issued];
      end else begin
        req_valid_i = 1'b0;
      end
      rnd         = $random(seed);
      rsp_ready_i = rnd[1:0] != 2'b00;
      // Sample just before the rising edge
      #3;
      if (rsp_valid_o && rsp_ready_i) begin
        exp = exp_q.pop_front();
        check_rsp(name_q[done], exp, rsp_o);
        done++;
      end
      if (req_valid_i && req_ready_o) begin
        issued++;
      end
    end
    @(negedge clk);
    req_valid_i = 1'b0;
    rsp_ready_i = 1'b1;
    // Pipe should now be empty
    repeat (3) begin
      @(posedge clk);
      #1;
      if (rsp_valid_o) begin
        stop_with_error("Extra lookup response after all expected ones");
      end
    end
    @(negedge clk);
    rsp_ready_i = 1'b0;
    req_q.delete();
    name_q.delete();
  endtask

  //////////////////////////////
  // Test data
  //////////////////////////////

  task automatic load_test_data();
    int    fd;
    int    line_no;
    string line;
    fd = $fopen("verification/dmmu_testdata.txt", "r");
    if (fd == 0) begin
      stop_with_error("Could not open the test data file");
    end else begin
      line_no = 0;
      while (!$feof(fd)) begin
        line = "";
        line_no++;
        // Skip blanks and comment lines
        if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
          lines.push_back(line);
          line_nos.push_back(line_no);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_line(input string line, input int line_no);
    byte         cmd;
    int          n;
    logic [31:0] addr;
    logic [31:0] dat;
    logic [31:0] vaddr;
    logic [31:0] paddr;
    logic        ld;
    logic        st;
    logic        sup;
    logic        miss;
    logic        fault;
    logic        ci;
    dmmu_req_t   req;
    dmmu_rsp_t   rsp;
    cmd = line[0];
    if (cmd == "L") begin
      n = $sscanf(line, "%c %h %h %h %h %h %h %h %h",
                  cmd, vaddr, ld, st, sup, paddr, miss, fault, ci);
      if (n != 9) begin
        stop_with_error($sformatf("Malformed lookup at line %0d", line_no));
      end else begin
        req.vaddr          = vaddr;
        req.op_load        = ld;
        req.op_store       = st;
        req.supervisor     = sup;
        rsp.paddr          = paddr;
        rsp.tlb_miss       = miss;
        rsp.pagefault      = fault;
        rsp.cache_inhibit  = ci;
        req_q.push_back(req);
        exp_q.push_back(rsp);
        name_q.push_back($sformatf("lookup line %0d", line_no));
      end
    end else if (cmd == "W" || cmd == "R") begin
      // Lookups and SPR traffic stay in separate phases
      if (req_q.size() > 0) begin
        run_lookups();
      end
      n = $sscanf(line, "%c %h %h", cmd, addr, dat);
      if (n != 3) begin
        stop_with_error($sformatf("Malformed SPR access at line %0d", line_no));
      end else begin
        spr_access($sformatf("spr line %0d", line_no), addr[spr_addr_w-1:0],
                   cmd == "W", dat);
      end
    end else begin
      stop_with_error($sformatf("Unknown command at line %0d", line_no));
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    rst         = 1'b1;
    spr_stb_i   = 1'b0;
    spr_req_i   = '0;
    req_valid_i = 1'b0;
    req_i       = '0;
    rsp_ready_i = 1'b0;
    load_test_data();
    if (lines.size() == 0) begin
      stop_with_error("Test data file holds no commands");
    end else begin
      cycle_limit = 20 * lines.size() + 200;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      foreach (lines[i]) begin
        run_line(lines[i], line_nos[i]);
      end
      // Last batch of lookups
      if (req_q.size() > 0) begin
        run_lookups();
      end
      $display("Verification passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verification/dmmu_testdata.txt
# W spr_addr data | R spr_addr expected_data (hex)
# L vaddr load store supervisor | expected paddr miss fault ci
W 0A05 0008A001
W 0A85 2468A3C2
W 0A09 FFE92001
W 0A89 01578301
W 0A0C 00018000
W 0A8C 00FFF3C2
W 0A3F 7FFFE001
W 0ABF FFFFE140
W 0A40 DEADBEEF
R 0A05 0008A001
R 0A85 2468A3C2
R 0A09 FFE92001
R 0A89 01578301
R 0A0C 00018000
R 0ABF FFFFE140
R 0A40 00000000
R 0AC0 00000000
L 0008A123 1 0 0 2468A123 0 0 1
L 0008A000 0 1 1 2468A000 0 0 1
L FFE93FFF 0 1 1 01579FFF 0 0 0
L FFE93FFF 0 1 0 01579FFF 0 1 0
L FFE92004 1 0 0 01578004 0 1 0
L FFE92004 1 0 1 01578004 0 0 0
L 00018010 1 0 0 00000000 1 0 0
L 0000A010 0 1 0 00000000 1 0 0
L 7FFFE800 1 0 0 FFFFE800 0 0 0
L 7FFFE800 0 1 0 FFFFE800 0 1 0
L 7FFFE800 0 1 1 FFFFE800 0 1 0
L 0008BFFF 1 0 1 2468BFFF 0 0 1
W 0A85 000023C1
R 0A85 000023C1
L 0008A123 0 1 1 00002123 0 0 0
L 0008A123 1 0 0 00002123 0 0 0

// File: vlog.f
source/dmmu_pkg.sv
source/dtlb_ram.sv
source/dmmu_spr_regs.sv
source/dtlb_lookup.sv
source/dmmu_top.sv
verification/dmmu_tb.sv
